// File: flist.f
src/matmul_pkg.sv
src/dual_port_ram.sv
src/matrix_buffers.sv
src/mac_array.sv
src/tile_sequencer.sv
src/apb_config_regs.sv
src/matrix_multiplication.sv
testbench/matmul_props.sv
testbench/tb_matmul.sv

// File: src/apb_config_regs.sv
module apb_config_regs #(
  parameter int MAT_MUL_SIZE = matmul_pkg::DEFAULT_MAT_MUL_SIZE
) (
  input  logic                              clk,
  input  logic                              PRESETn,
  input  matmul_pkg::apb_req_t              apb_req,
  output logic [matmul_pkg::REG_DWIDTH-1:0] prdata,
  output logic                              pready,
  output matmul_pkg::mm_cfg_t               cfg,
  output logic                              start,
  output logic                              clear_done,
  input  logic                              busy,
  input  logic                              done
);
  import matmul_pkg::*;

  apb_state_e            apb_state;
  // Catches accesses to unmapped addresses
  logic [REG_DWIDTH-1:0] scratch;

  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      apb_state    <= IDLE;
      prdata       <= '0;
      pready       <= 1'b0;
      start        <= 1'b0;
      clear_done   <= 1'b0;
      scratch      <= '0;
      cfg.addr_a   <= '0;
      cfg.addr_b   <= '0;
      cfg.addr_c   <= '0;
      cfg.stride_a <= STRIDE_WIDTH'(MAT_MUL_SIZE);
      cfg.stride_b <= STRIDE_WIDTH'(MAT_MUL_SIZE);
      cfg.stride_c <= STRIDE_WIDTH'(MAT_MUL_SIZE);
    end else begin
      // Ready is a single-cycle pulse
      pready <= 1'b0;
      case (apb_state)
        IDLE: begin
          prdata <= '0;
          // New transfer only on the setup phase
          if (apb_req.psel && !apb_req.penable) begin
            apb_state <= apb_req.pwrite ? W_ENABLE : R_ENABLE;
          end
        end

        W_ENABLE: begin
          if (apb_req.psel && apb_req.penable && apb_req.pwrite) begin
            case (apb_req.paddr)
              REG_CTRL: begin
                start      <= apb_req.pwdata[0];
                clear_done <= apb_req.pwdata[REG_DWIDTH-1];
              end
              REG_ADDR_A:   cfg.addr_a   <= apb_req.pwdata[AWIDTH-1:0];
              REG_ADDR_B:   cfg.addr_b   <= apb_req.pwdata[AWIDTH-1:0];
              REG_ADDR_C:   cfg.addr_c   <= apb_req.pwdata[AWIDTH-1:0];
              REG_STRIDE_A: cfg.stride_a <= apb_req.pwdata[STRIDE_WIDTH-1:0];
              REG_STRIDE_B: cfg.stride_b <= apb_req.pwdata[STRIDE_WIDTH-1:0];
              REG_STRIDE_C: cfg.stride_c <= apb_req.pwdata[STRIDE_WIDTH-1:0];
              default:      scratch      <= apb_req.pwdata;
            endcase
            pready <= 1'b1;
          end
          apb_state <= IDLE;
        end

        R_ENABLE: begin
          if (apb_req.psel && apb_req.penable && !apb_req.pwrite) begin
            case (apb_req.paddr)
              // Status: done on top, busy at the bottom
              REG_CTRL:     prdata <= {done, {(REG_DWIDTH-2){1'b0}}, busy};
              REG_ADDR_A:   prdata <= REG_DWIDTH'(cfg.addr_a);
              REG_ADDR_B:   prdata <= REG_DWIDTH'(cfg.addr_b);
              REG_ADDR_C:   prdata <= REG_DWIDTH'(cfg.addr_c);
              REG_STRIDE_A: prdata <= REG_DWIDTH'(cfg.stride_a);
              REG_STRIDE_B: prdata <= REG_DWIDTH'(cfg.stride_b);
              REG_STRIDE_C: prdata <= REG_DWIDTH'(cfg.stride_c);
              default:      prdata <= scratch;
            endcase
            pready <= 1'b1;
          end
          apb_state <= IDLE;
        end

        default: begin
          apb_state <= IDLE;
        end
      endcase
    end
  end

endmodule

// File: src/dual_port_ram.sv
module dual_port_ram #(
  parameter int MAT_MUL_SIZE = matmul_pkg::DEFAULT_MAT_MUL_SIZE
) (
  input  logic                                         clk,
  input  logic [matmul_pkg::AWIDTH-1:0]                addr0,
  input  logic [MAT_MUL_SIZE*matmul_pkg::DWIDTH-1:0]   d0,
  input  logic                                         we0,
  output logic [MAT_MUL_SIZE*matmul_pkg::DWIDTH-1:0]   q0,
  input  logic [matmul_pkg::AWIDTH-1:0]                addr1,
  input  logic [MAT_MUL_SIZE*matmul_pkg::DWIDTH-1:0]   d1,
  input  logic                                         we1,
  output logic [MAT_MUL_SIZE*matmul_pkg::DWIDTH-1:0]   q1
);
  import matmul_pkg::*;

  // One byte per location
  logic [DWIDTH-1:0] mem [0:(1<<AWIDTH)-1];

  // A word spans MAT_MUL_SIZE bytes, wrapping at the top of memory
  always_ff @(posedge clk) begin
    for (int i = 0; i < MAT_MUL_SIZE; i++) begin
      q0[i*DWIDTH +: DWIDTH] <= mem[addr0 + AWIDTH'(i)];
      q1[i*DWIDTH +: DWIDTH] <= mem[addr1 + AWIDTH'(i)];
    end
    if (we0) begin
      for (int i = 0; i < MAT_MUL_SIZE; i++) begin
        mem[addr0 + AWIDTH'(i)] <= d0[i*DWIDTH +: DWIDTH];
      end
    end
    // Port 1 wins on a collision
    if (we1) begin
      for (int i = 0; i < MAT_MUL_SIZE; i++) begin
        mem[addr1 + AWIDTH'(i)] <= d1[i*DWIDTH +: DWIDTH];
      end
    end
  end

endmodule

// File: src/mac_array.sv
module mac_array #(
  parameter int MAT_MUL_SIZE = matmul_pkg::DEFAULT_MAT_MUL_SIZE
) (
  input  logic                                       clk,
  input  logic                                       PRESETn,
  input  logic                                       acc_clear,
  input  logic                                       acc_en,
  input  logic [MAT_MUL_SIZE*matmul_pkg::DWIDTH-1:0] a_col,
  input  logic [MAT_MUL_SIZE*matmul_pkg::DWIDTH-1:0] b_row,
  input  logic [$clog2(MAT_MUL_SIZE)-1:0]            row_sel,
  output logic [MAT_MUL_SIZE*matmul_pkg::DWIDTH-1:0] c_row
);
  import matmul_pkg::*;

  // Full product width plus growth over N terms
  localparam int ACC_W = 2 * DWIDTH + $clog2(MAT_MUL_SIZE);

  logic signed [ACC_W-1:0]  acc [MAT_MUL_SIZE][MAT_MUL_SIZE];
  logic signed [DWIDTH-1:0] a_elem [MAT_MUL_SIZE];
  logic signed [DWIDTH-1:0] b_elem [MAT_MUL_SIZE];

  // Unpack the operand words into signed elements
  always_comb begin
    for (int k = 0; k < MAT_MUL_SIZE; k++) begin
      a_elem[k] = a_col[k*DWIDTH +: DWIDTH];
      b_elem[k] = b_row[k*DWIDTH +: DWIDTH];
    end
  end

  //////////////////////////////
  // Outer product accumulate
  //////////////////////////////

  always_ff @(posedge clk) begin
    for (int i = 0; i < MAT_MUL_SIZE; i++) begin
      for (int j = 0; j < MAT_MUL_SIZE; j++) begin
        if (!PRESETn || acc_clear) begin
          acc[i][j] <= '0;
        end else if (acc_en) begin
          acc[i][j] <= acc[i][j] + a_elem[i] * b_elem[j];
        end
      end
    end
  end

  // Truncated readout of one row
  always_comb begin
    for (int j = 0; j < MAT_MUL_SIZE; j++) begin
      c_row[j*DWIDTH +: DWIDTH] = acc[row_sel][j][DWIDTH-1:0];
    end
  end

endmodule

// File: src/matmul_pkg.sv
package matmul_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Element and memory sizes
  localparam int DWIDTH = 8;
  localparam int AWIDTH = 10;

  // APB bus
  localparam int REG_DWIDTH = 32;
  localparam int REG_AWIDTH = 8;

  localparam int STRIDE_WIDTH = 16;

  // Tile edge, overridden from the top level
  localparam int DEFAULT_MAT_MUL_SIZE = 4;

  //////////////////////////////
  // Register map
  //////////////////////////////

  typedef enum logic [REG_AWIDTH-1:0] {
    REG_CTRL     = 8'h04,
    REG_STRIDE_C = 8'h03,
    REG_ADDR_A   = 8'h0E,
    REG_ADDR_B   = 8'h12,
    REG_ADDR_C   = 8'h16,
    REG_STRIDE_A = 8'h28,
    REG_STRIDE_B = 8'h32
  } reg_addr_e;

  // APB slave states
  typedef enum logic [1:0] {
    IDLE,
    W_ENABLE,
    R_ENABLE
  } apb_state_e;

  // Engine run states
  typedef enum logic [2:0] {
    RUN_IDLE,
    RUN_LOAD,
    RUN_DRAIN,
    RUN_WRITE,
    RUN_DONE
  } run_state_e;

  //////////////////////////////
  // Shared structs
  //////////////////////////////

  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [REG_AWIDTH-1:0] paddr;
    logic [REG_DWIDTH-1:0] pwdata;
  } apb_req_t;

  // Tile layout in the three memories
  typedef struct packed {
    logic [AWIDTH-1:0]       addr_a;
    logic [AWIDTH-1:0]       addr_b;
    logic [AWIDTH-1:0]       addr_c;
    logic [STRIDE_WIDTH-1:0] stride_a;
    logic [STRIDE_WIDTH-1:0] stride_b;
    logic [STRIDE_WIDTH-1:0] stride_c;
  } mm_cfg_t;

endpackage

// File: src/matrix_buffers.sv
module matrix_buffers #(
  parameter int MAT_MUL_SIZE = matmul_pkg::DEFAULT_MAT_MUL_SIZE
) (
  input  logic                                       clk,
  input  logic                                       PRESETn,
  input  logic [1:0]                                 bank_sel,
  input  logic [matmul_pkg::AWIDTH-1:0]              ext_addr,
  input  logic [MAT_MUL_SIZE*matmul_pkg::DWIDTH-1:0] ext_wdata,
  input  logic                                       ext_we,
  output logic [MAT_MUL_SIZE*matmul_pkg::DWIDTH-1:0] ext_rdata,
  input  logic [matmul_pkg::AWIDTH-1:0]              a_addr,
  output logic [MAT_MUL_SIZE*matmul_pkg::DWIDTH-1:0] a_data,
  input  logic [matmul_pkg::AWIDTH-1:0]              b_addr,
  output logic [MAT_MUL_SIZE*matmul_pkg::DWIDTH-1:0] b_data,
  input  logic [matmul_pkg::AWIDTH-1:0]              c_addr,
  input  logic [MAT_MUL_SIZE*matmul_pkg::DWIDTH-1:0] c_wdata,
  input  logic                                       c_we
);
  import matmul_pkg::*;

  localparam int WORD_W = MAT_MUL_SIZE * DWIDTH;

  logic [1:0]        bank_q;
  logic [WORD_W-1:0] ext_q_a;
  logic [WORD_W-1:0] ext_q_b;
  logic [WORD_W-1:0] ext_q_c;

  // Bank of the previous cycle selects the returned word
  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      bank_q <= 2'd0;
    end else begin
      bank_q <= bank_sel;
    end
  end

  always_comb begin
    case (bank_q)
      2'd0:    ext_rdata = ext_q_a;
      2'd1:    ext_rdata = ext_q_b;
      2'd2:    ext_rdata = ext_q_c;
      default: ext_rdata = '0;
    endcase
  end

  //////////////////////////////
  // Port 0 engine, port 1 host
  //////////////////////////////

  dual_port_ram #(.MAT_MUL_SIZE(MAT_MUL_SIZE)) u_ram_a (
    .clk(clk), .addr0(a_addr), .d0('0), .we0(1'b0), .q0(a_data),
    .addr1(ext_addr), .d1(ext_wdata), .we1(ext_we && bank_sel == 2'd0), .q1(ext_q_a)
  );

  dual_port_ram #(.MAT_MUL_SIZE(MAT_MUL_SIZE)) u_ram_b (
    .clk(clk), .addr0(b_addr), .d0('0), .we0(1'b0), .q0(b_data),
    .addr1(ext_addr), .d1(ext_wdata), .we1(ext_we && bank_sel == 2'd1), .q1(ext_q_b)
  );

  // Engine only writes C
  dual_port_ram #(.MAT_MUL_SIZE(MAT_MUL_SIZE)) u_ram_c (
    .clk(clk), .addr0(c_addr), .d0(c_wdata), .we0(c_we), .q0(),
    .addr1(ext_addr), .d1(ext_wdata), .we1(ext_we && bank_sel == 2'd2), .q1(ext_q_c)
  );

endmodule

// File: src/matrix_multiplication.sv
module matrix_multiplication #(
  parameter int MAT_MUL_SIZE = matmul_pkg::DEFAULT_MAT_MUL_SIZE
) (
  input  logic                                       clk,
  input  logic                                       PRESETn,
  input  matmul_pkg::apb_req_t                       apb_req,
  output logic [matmul_pkg::REG_DWIDTH-1:0]          prdata,
  output logic                                       pready,
  input  logic [1:0]                                 bank_sel,
  input  logic [matmul_pkg::AWIDTH-1:0]              ext_addr,
  input  logic [MAT_MUL_SIZE*matmul_pkg::DWIDTH-1:0] ext_wdata,
  input  logic                                       ext_we,
  output logic [MAT_MUL_SIZE*matmul_pkg::DWIDTH-1:0] ext_rdata
);
  import matmul_pkg::*;

  localparam int WORD_W = MAT_MUL_SIZE * DWIDTH;

  // Configuration and control
  mm_cfg_t cfg;
  logic    start;
  logic    clear_done;
  logic    busy;
  logic    done;

  // Engine memory ports
  logic [AWIDTH-1:0] a_addr;
  logic [AWIDTH-1:0] b_addr;
  logic [AWIDTH-1:0] c_addr;
  logic [WORD_W-1:0] a_data;
  logic [WORD_W-1:0] b_data;
  logic [WORD_W-1:0] c_wdata;
  logic              c_we;

  // Array control
  logic                            acc_clear;
  logic                            acc_en;
  logic [$clog2(MAT_MUL_SIZE)-1:0] row_sel;
  logic [WORD_W-1:0]               c_row;

  apb_config_regs #(.MAT_MUL_SIZE(MAT_MUL_SIZE)) u_apb_config_regs (
    .clk(clk), .PRESETn(PRESETn), .apb_req(apb_req), .prdata(prdata), .pready(pready),
    .cfg(cfg), .start(start), .clear_done(clear_done), .busy(busy), .done(done)
  );

  matrix_buffers #(.MAT_MUL_SIZE(MAT_MUL_SIZE)) u_matrix_buffers (
    .clk(clk), .PRESETn(PRESETn), .bank_sel(bank_sel), .ext_addr(ext_addr),
    .ext_wdata(ext_wdata), .ext_we(ext_we), .ext_rdata(ext_rdata),
    .a_addr(a_addr), .a_data(a_data), .b_addr(b_addr), .b_data(b_data),
    .c_addr(c_addr), .c_wdata(c_wdata), .c_we(c_we)
  );

  tile_sequencer #(.MAT_MUL_SIZE(MAT_MUL_SIZE)) u_tile_sequencer (
    .clk(clk), .PRESETn(PRESETn), .start(start), .clear_done(clear_done), .cfg(cfg),
    .busy(busy), .done(done), .a_addr(a_addr), .b_addr(b_addr), .c_addr(c_addr),
    .c_wdata(c_wdata), .c_we(c_we), .acc_clear(acc_clear), .acc_en(acc_en),
    .row_sel(row_sel), .c_row(c_row)
  );

  mac_array #(.MAT_MUL_SIZE(MAT_MUL_SIZE)) u_mac_array (
    .clk(clk), .PRESETn(PRESETn), .acc_clear(acc_clear), .acc_en(acc_en),
    .a_col(a_data), .b_row(b_data), .row_sel(row_sel), .c_row(c_row)
  );

endmodule

// File: src/tile_sequencer.sv
module tile_sequencer #(
  parameter int MAT_MUL_SIZE = matmul_pkg::DEFAULT_MAT_MUL_SIZE
) (
  input  logic                                       clk,
  input  logic                                       PRESETn,
  input  logic                                       start,
  input  logic                                       clear_done,
  input  matmul_pkg::mm_cfg_t                        cfg,
  output logic                                       busy,
  output logic                                       done,
  output logic [matmul_pkg::AWIDTH-1:0]              a_addr,
  output logic [matmul_pkg::AWIDTH-1:0]              b_addr,
  output logic [matmul_pkg::AWIDTH-1:0]              c_addr,
  output logic [MAT_MUL_SIZE*matmul_pkg::DWIDTH-1:0] c_wdata,
  output logic                                       c_we,
  output logic                                       acc_clear,
  output logic                                       acc_en,
  output logic [$clog2(MAT_MUL_SIZE)-1:0]            row_sel,
  input  logic [MAT_MUL_SIZE*matmul_pkg::DWIDTH-1:0] c_row
);
  import matmul_pkg::*;

  localparam int               CNT_W = $clog2(MAT_MUL_SIZE);
  localparam logic [CNT_W-1:0] LAST  = CNT_W'(MAT_MUL_SIZE - 1);

  run_state_e       run_state;
  // k index while loading, row index while writing
  logic [CNT_W-1:0] cnt;
  logic             last_step;
  // Read issued last cycle, data is on the memory outputs now
  logic             rd_pending;

  assign last_step = (cnt == LAST);

  //////////////////////////////
  // Run FSM and address steps
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      run_state  <= RUN_IDLE;
      cnt        <= '0;
      rd_pending <= 1'b0;
      a_addr     <= '0;
      b_addr     <= '0;
      c_addr     <= '0;
    end else begin
      rd_pending <= (run_state == RUN_LOAD);
      case (run_state)
        RUN_IDLE: begin
          if (start) begin
            a_addr    <= cfg.addr_a;
            b_addr    <= cfg.addr_b;
            c_addr    <= cfg.addr_c;
            cnt       <= '0;
            run_state <= RUN_LOAD;
          end
        end

        // One column of A and one row of B per cycle
        RUN_LOAD: begin
          a_addr <= a_addr + cfg.stride_a[AWIDTH-1:0];
          b_addr <= b_addr + cfg.stride_b[AWIDTH-1:0];
          if (last_step) begin
            cnt       <= '0;
            run_state <= RUN_DRAIN;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end

        // Last accumulate lands here
        RUN_DRAIN: begin
          cnt       <= '0;
          run_state <= RUN_WRITE;
        end

        RUN_WRITE: begin
          c_addr <= c_addr + cfg.stride_c[AWIDTH-1:0];
          if (last_step) begin
            cnt       <= '0;
            run_state <= RUN_DONE;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end

        // Hold done for the host
        RUN_DONE: begin
          if (clear_done) begin
            run_state <= RUN_IDLE;
          end
        end

        default: begin
          run_state <= RUN_IDLE;
        end
      endcase
    end
  end

  // Accumulators start from zero on every run
  assign acc_clear = (run_state == RUN_IDLE) && start;
  assign acc_en    = rd_pending;

  // Row write-back straight from the array
  assign row_sel = cnt;
  assign c_we    = (run_state == RUN_WRITE);
  assign c_wdata = c_row;

  assign busy = (run_state != RUN_IDLE) && (run_state != RUN_DONE);
  assign done = (run_state == RUN_DONE);

endmodule

// File: testbench/matmul_props.sv
module matmul_props (
  input logic                 clk,
  input logic                 PRESETn,
  input matmul_pkg::apb_req_t apb_req,
  input logic                 pready,
  input logic                 clear_done,
  input logic                 busy,
  input logic                 done
);

  //////////////////////////////
  // APB ready
  //////////////////////////////

  ready_one_cycle: assert property (@(posedge clk) disable iff (!PRESETn)
    pready |=> !pready)
    else $error("pready stayed high for two cycles");

  // Access phase seen on the edge before
  ready_after_access: assert property (@(posedge clk) disable iff (!PRESETn)
    $rose(pready) |-> $past(apb_req.psel && apb_req.penable))
    else $error("pready rose without an access cycle");

  //////////////////////////////
  // Run control
  //////////////////////////////

  busy_done_exclusive: assert property (@(posedge clk) disable iff (!PRESETn)
    !(busy && done))
    else $error("busy and done high together");

  done_held: assert property (@(posedge clk) disable iff (!PRESETn)
    done && !clear_done |=> done)
    else $error("done dropped without clear_done");

endmodule

// Busy and done arrive here straight from the sequencer
bind apb_config_regs matmul_props u_matmul_props (
  .clk(clk), .PRESETn(PRESETn), .apb_req(apb_req), .pready(pready),
  .clear_done(clear_done), .busy(busy), .done(done)
);

// File: testbench/tb_matmul.sv
module tb_matmul;
  import matmul_pkg::*;

  localparam int N          = DEFAULT_MAT_MUL_SIZE;
  localparam int WORD_W     = N * DWIDTH;
  localparam int MAX_CYCLES = 4000;
  // Latency limit for done plus the length of one status read
  localparam int DONE_BOUND = 2 * N + 4 + 6;

  logic                  clk = 1'b0;
  logic                  PRESETn;
  apb_req_t              apb_req;
  logic [REG_DWIDTH-1:0] prdata;
  logic                  pready;
  logic [1:0]            bank_sel;
  logic [AWIDTH-1:0]     ext_addr;
  logic [WORD_W-1:0]     ext_wdata;
  logic                  ext_we;
  logic [WORD_W-1:0]     ext_rdata;

  int          errors    = 0;
  int          checks    = 0;
  int          cycle_cnt = 0;
  logic [31:0] lcg_state = 32'd81;

  // Reference operands, indexed [row][col]
  logic signed [DWIDTH-1:0] mat_a [N][N];
  logic signed [DWIDTH-1:0] mat_b [N][N];

  matrix_multiplication #(.MAT_MUL_SIZE(N)) UUT (
    .clk(clk), .PRESETn(PRESETn), .apb_req(apb_req), .prdata(prdata), .pready(pready),
    .bank_sel(bank_sel), .ext_addr(ext_addr), .ext_wdata(ext_wdata), .ext_we(ext_we),
    .ext_rdata(ext_rdata)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: tests still running after %0d cycles", cycle_cnt);
      $display("Summary: %0d checks, %0d errors", checks, errors);
      $display("Test failed");
      $finish;
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [DWIDTH-1:0] rand_byte();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  function automatic logic [WORD_W-1:0] random_word();
    logic [WORD_W-1:0] w;
    for (int b = 0; b < N; b++) begin
      w[b*DWIDTH +: DWIDTH] = rand_byte();
    end
    return w;
  endfunction

  // Background bytes, a function of all address bits
  function automatic logic [WORD_W-1:0] fill_word(input logic [AWIDTH-1:0] addr);
    logic [WORD_W-1:0] w;
    logic [AWIDTH-1:0] x;
    for (int b = 0; b < N; b++) begin
      x = addr + AWIDTH'(b);
      w[b*DWIDTH +: DWIDTH] = x[7:0] ^ {4{x[9:8]}};
    end
    return w;
  endfunction

  // Exact signed dot product, keep the low byte
  function automatic logic [DWIDTH-1:0] ref_element(input int i, input int j);
    int sum;
    sum = 0;
    for (int k = 0; k < N; k++) begin
      sum += int'(mat_a[i][k]) * int'(mat_b[k][j]);
    end
    return sum[DWIDTH-1:0];
  endfunction

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("error at time %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  //////////////////////////////
  // Bus tasks
  //////////////////////////////

  task automatic apb_transfer(input logic write, input logic [REG_AWIDTH-1:0] addr,
                              input logic [REG_DWIDTH-1:0] wdata,
                              output logic [REG_DWIDTH-1:0] rdata);
    apb_req_t req;
    int       waited;
    req    = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
    waited = 0;
    rdata  = '0;
    @(posedge clk);
    apb_req <= req;
    @(posedge clk);
    req.penable = 1'b1;
    apb_req <= req;
    do begin
      @(posedge clk);
      waited++;
    end while (!pready && waited < 4);
    if (pready) begin
      rdata = prdata;
    end else begin
      errors++;
      $display("APB transfer to address 0x%0h never got a ready", addr);
    end
    apb_req <= '0;
  endtask

  task automatic apb_write(input logic [REG_AWIDTH-1:0] addr, input logic [REG_DWIDTH-1:0] data);
    logic [REG_DWIDTH-1:0] unused;
    apb_transfer(1'b1, addr, data, unused);
  endtask

  task automatic apb_read(input logic [REG_AWIDTH-1:0] addr, output logic [REG_DWIDTH-1:0] data);
    apb_transfer(1'b0, addr, '0, data);
  endtask

  task automatic mem_write(input logic [1:0] bank, input logic [AWIDTH-1:0] addr,
                           input logic [WORD_W-1:0] data);
    @(posedge clk);
    bank_sel  <= bank;
    ext_addr  <= addr;
    ext_wdata <= data;
    ext_we    <= 1'b1;
    @(posedge clk);
    ext_we <= 1'b0;
  endtask

  task automatic mem_read(input logic [1:0] bank, input logic [AWIDTH-1:0] addr,
                          output logic [WORD_W-1:0] data);
    @(posedge clk);
    bank_sel <= bank;
    ext_addr <= addr;
    ext_we   <= 1'b0;
    @(posedge clk);
    @(posedge clk);
    data = ext_rdata;
  endtask

  //////////////////////////////
  // Tile helpers
  //////////////////////////////

  task automatic randomize_operands(input bit identity_a);
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        mat_a[i][j] = identity_a ? DWIDTH'(i == j) : rand_byte();
        mat_b[i][j] = rand_byte();
      end
    end
  endtask

  // A goes in by columns, B by rows
  task automatic store_operands(input logic [AWIDTH-1:0] base_a, input int stride_a,
                                input logic [AWIDTH-1:0] base_b, input int stride_b);
    logic [WORD_W-1:0] col;
    logic [WORD_W-1:0] row;
    for (int k = 0; k < N; k++) begin
      for (int i = 0; i < N; i++) begin
        col[i*DWIDTH +: DWIDTH] = mat_a[i][k];
        row[i*DWIDTH +: DWIDTH] = mat_b[k][i];
      end
      mem_write(2'd0, AWIDTH'(base_a + k * stride_a), col);
      mem_write(2'd1, AWIDTH'(base_b + k * stride_b), row);
    end
  endtask

  task automatic set_layout(input int addr_a, input int stride_a, input int addr_b,
                            input int stride_b, input int addr_c, input int stride_c);
    apb_write(REG_ADDR_A, addr_a);
    apb_write(REG_STRIDE_A, stride_a);
    apb_write(REG_ADDR_B, addr_b);
    apb_write(REG_STRIDE_B, stride_b);
    apb_write(REG_ADDR_C, addr_c);
    apb_write(REG_STRIDE_C, stride_c);
  endtask

  // Start, poll status until done, then clear it
  task automatic run_tile(output bit saw_busy);
    logic [REG_DWIDTH-1:0] status;
    int                    t_start;
    saw_busy = 1'b0;
    status   = '0;
    apb_write(REG_CTRL, 32'h1);
    t_start = cycle_cnt;
    while (!status[31] && cycle_cnt - t_start <= DONE_BOUND) begin
      apb_read(REG_CTRL, status);
      if (status[0]) saw_busy = 1'b1;
    end
    if (!status[31]) begin
      errors++;
      $display("done did not rise within %0d cycles of the start write", DONE_BOUND);
    end
    apb_read(REG_CTRL, status);
    check_value("status while done", status, 32'h8000_0000);
    apb_write(REG_CTRL, 32'h8000_0000);
    apb_read(REG_CTRL, status);
    check_value("status after clear_done", status, 32'h0);
  endtask

  task automatic check_c_rows(input logic [AWIDTH-1:0] base_c, input int stride_c,
                              input bit expect_b);
    logic [WORD_W-1:0] got;
    logic [WORD_W-1:0] exp;
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        exp[j*DWIDTH +: DWIDTH] = expect_b ? mat_b[i][j] : ref_element(i, j);
      end
      mem_read(2'd2, AWIDTH'(base_c + i * stride_c), got);
      check_value($sformatf("C row %0d", i), got, exp);
    end
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic test_register_access();
    logic [REG_AWIDTH-1:0] addrs [6];
    logic [REG_DWIDTH-1:0] values [6];
    logic [REG_DWIDTH-1:0] data;
    addrs  = '{REG_ADDR_A, REG_ADDR_B, REG_ADDR_C, REG_STRIDE_A, REG_STRIDE_B, REG_STRIDE_C};
    values = '{32'h1A5, 32'h2C3, 32'h37E, 32'h0123, 32'hBEEF, 32'h0042};
    apb_read(REG_CTRL, data);
    check_value("status after reset", data, 32'h0);
    for (int r = 0; r < 6; r++) begin
      apb_read(addrs[r], data);
      check_value($sformatf("register 0x%0h after reset", addrs[r]), data,
                  r < 3 ? 32'd0 : 32'(N));
    end
    for (int r = 0; r < 6; r++) begin
      apb_write(addrs[r], values[r]);
    end
    for (int r = 0; r < 6; r++) begin
      apb_read(addrs[r], data);
      check_value($sformatf("register 0x%0h", addrs[r]), data, values[r]);
    end
    // Unmapped addresses share the scratch register
    apb_write(8'h40, 32'hC0DE_5A17);
    apb_read(8'h40, data);
    check_value("scratch at 0x40", data, 32'hC0DE_5A17);
    apb_read(8'h7C, data);
    check_value("scratch at 0x7C", data, 32'hC0DE_5A17);
    set_layout(0, N, 0, N, 0, N);
  endtask

  task automatic test_memory_port();
    logic [WORD_W-1:0] words [3];
    logic [WORD_W-1:0] got;
    for (int b = 0; b < 3; b++) begin
      words[b] = random_word();
      mem_write(2'(b), 10'h300, words[b]);
    end
    for (int b = 0; b < 3; b++) begin
      mem_read(2'(b), 10'h300, got);
      check_value($sformatf("bank %0d word", b), got, words[b]);
    end
    mem_read(2'd3, 10'h300, got);
    check_value("bank 3 word", got, '0);
  endtask

  task automatic test_identity_product();
    bit saw_busy;
    randomize_operands(1'b1);
    store_operands(0, N, 0, N);
    run_tile(saw_busy);
    check_c_rows(0, N, 1'b1);
  endtask

  task automatic test_random_product();
    bit saw_busy;
    randomize_operands(1'b0);
    store_operands(0, N, 0, N);
    run_tile(saw_busy);
    check_c_rows(0, N, 1'b0);
  endtask

  task automatic test_custom_layout();
    logic [AWIDTH-1:0] base_c;
    logic [AWIDTH-1:0] gap;
    logic [WORD_W-1:0] got;
    int                stride_c;
    bit                saw_busy;
    base_c   = 10'h2E0;
    stride_c = 2 * N;
    // Background in the C region so untouched bytes show up
    for (int x = 0; x < N * stride_c; x += N) begin
      mem_write(2'd2, AWIDTH'(base_c + x), fill_word(AWIDTH'(base_c + x)));
    end
    randomize_operands(1'b0);
    set_layout(10'h0A0, N + 2, 10'h155, 2 * N, base_c, stride_c);
    store_operands(10'h0A0, N + 2, 10'h155, 2 * N);
    run_tile(saw_busy);
    check_c_rows(base_c, stride_c, 1'b0);
    for (int i = 0; i < N; i++) begin
      gap = AWIDTH'(base_c + i * stride_c + N);
      mem_read(2'd2, gap, got);
      check_value($sformatf("C gap at 0x%0h", gap), got, fill_word(gap));
    end
    set_layout(0, N, 0, N, 0, N);
  endtask

  task automatic test_status_control();
    bit saw_busy;
    for (int run = 0; run < 2; run++) begin
      randomize_operands(1'b0);
      store_operands(0, N, 0, N);
      run_tile(saw_busy);
      check_value($sformatf("busy seen in run %0d", run), saw_busy, 1);
      check_c_rows(0, N, 1'b0);
    end
  endtask

  initial begin
    PRESETn   = 1'b0;
    apb_req   = '0;
    bank_sel  = 2'd0;
    ext_addr  = '0;
    ext_wdata = '0;
    ext_we    = 1'b0;
    repeat (16) @(posedge clk);
    PRESETn <= 1'b1;

    test_register_access();
    test_memory_port();
    test_identity_product();
    test_random_product();
    test_custom_layout();
    test_status_control();

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
